//--- Makefile
BIN := obj_dir/Vtb_cache_subsystem

.PHONY: run clean

run: $(BIN)
	./$(BIN)

$(BIN): cache_subsystem.f $(shell cat cache_subsystem.f)
	verilator --binary --timing --assert --top-module tb_cache_subsystem -f cache_subsystem.f

clean:
	rm -rf obj_dir

//--- cache_subsystem.f
source/cache_pkg.sv
source/axi_pkg.sv
source/cache_store.sv
source/cache_ctrl.sv
source/line_biu.sv
source/cache_subsystem.sv
test/axi_mem_model.sv
test/tb_cache_subsystem.sv

//--- source/axi_pkg.sv
package axi_pkg;

    // Response codes on the rresp and bresp channels
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_t;

    // Bus interface unit states, one address phase and one completion phase per word
    typedef enum logic [2:0] {
        B_IDLE  = 3'b000,
        B_RADDR = 3'b001,
        B_RDATA = 3'b010,
        B_WADDR = 3'b011,
        B_WRESP = 3'b100
    } biu_state_t;

endpackage

//--- source/cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl #(
    parameter int  DATA_WIDTH      = cache_pkg::DATA_WIDTH,
    parameter int  ADDR_WIDTH      = cache_pkg::ADDR_WIDTH,
    parameter int  CACHE_SIZE      = cache_pkg::CACHE_SIZE,
    parameter int  CACHE_LINE_SIZE = cache_pkg::CACHE_LINE_SIZE,
    localparam int LINE_COUNT      = CACHE_SIZE / CACHE_LINE_SIZE,
    localparam int OFFSET_WIDTH    = $clog2(CACHE_LINE_SIZE),
    localparam int INDEX_WIDTH     = $clog2(LINE_COUNT),
    localparam int TAG_WIDTH       = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH,
    localparam int LINE_WIDTH      = CACHE_LINE_SIZE * 8
) (
    input  logic                  clk,
    input  logic                  n_rst,

    input  logic                  i_re,
    input  logic                  i_we,
    input  logic [ADDR_WIDTH-1:0] i_addr,
    input  logic [DATA_WIDTH-1:0] i_wdata,
    output logic [DATA_WIDTH-1:0] o_rdata,
    output logic                  o_hit,
    output logic                  o_busy,

    input  logic                  i_biu_done,
    input  logic [LINE_WIDTH-1:0] i_biu_data,
    output logic                  o_biu_en,
    output logic                  o_biu_we,
    output logic [ADDR_WIDTH-1:0] o_biu_addr,
    output logic [LINE_WIDTH-1:0] o_biu_data
);

    cache_pkg::ctrl_state_t        state_q;
    cache_pkg::ctrl_state_t        state_d;

    logic [OFFSET_WIDTH-1:0]       offset;
    logic [INDEX_WIDTH-1:0]        index;
    logic [TAG_WIDTH-1:0]          tag;

    logic                          store_hit;
    logic                          store_we;
    logic                          store_fe;
    logic                          res_dirty;
    logic [TAG_WIDTH-1:0]          res_tag;
    logic [LINE_WIDTH-1:0]         res_vdata;

    logic                          victimize;
    logic [LINE_WIDTH-1:0]         vdata_q;
    logic [ADDR_WIDTH-1:0]         vaddr_q;

    assign offset = i_addr[OFFSET_WIDTH-1:0];
    assign index  = i_addr[OFFSET_WIDTH +: INDEX_WIDTH];
    assign tag    = i_addr[ADDR_WIDTH-1 -: TAG_WIDTH];

    assign store_we  = (state_q == cache_pkg::IDLE) && i_we;
    assign store_fe  = (state_q == cache_pkg::MISS) && i_biu_done;
    assign victimize = store_fe && res_dirty;  // Old line is still readable at the fill edge

    assign o_hit      = (state_q == cache_pkg::IDLE) && store_hit;
    assign o_busy     = state_q != cache_pkg::IDLE;
    assign o_biu_en   = state_q != cache_pkg::IDLE;
    assign o_biu_we   = state_q == cache_pkg::VICTIM;
    assign o_biu_addr = (state_q == cache_pkg::VICTIM) ? vaddr_q :
                        {tag, index, {OFFSET_WIDTH{1'b0}}};
    assign o_biu_data = vdata_q;

    always_ff @(posedge clk) begin
        if (victimize) begin
            vdata_q <= res_vdata;
            vaddr_q <= {res_tag, index, {OFFSET_WIDTH{1'b0}}};
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state_q <= cache_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            cache_pkg::IDLE: begin
                if ((i_re || i_we) && !store_hit) begin
                    state_d = cache_pkg::MISS;
                end
            end
            cache_pkg::MISS: begin
                if (i_biu_done) begin
                    state_d = victimize ? cache_pkg::VICTIM : cache_pkg::IDLE;
                end
            end
            cache_pkg::VICTIM: begin
                if (i_biu_done) begin
                    state_d = cache_pkg::IDLE;
                end
            end
            default: state_d = cache_pkg::IDLE;
        endcase
    end

    cache_store #(
        .DATA_WIDTH(DATA_WIDTH),
        .ADDR_WIDTH(ADDR_WIDTH),
        .CACHE_SIZE(CACHE_SIZE),
        .CACHE_LINE_SIZE(CACHE_LINE_SIZE)
    ) store_inst (
        .clk(clk),
        .n_rst(n_rst),
        .i_re(i_re),
        .i_we(store_we),
        .i_fe(store_fe),
        .i_offset(offset),
        .i_index(index),
        .i_tag(tag),
        .i_fdata(i_biu_data),
        .i_wdata(i_wdata),
        .o_hit(store_hit),
        .o_dirty(res_dirty),
        .o_tag(res_tag),
        .o_vdata(res_vdata),
        .o_rdata(o_rdata)
    );

    // The bus unit stays quiet while the controller serves hits
    assert property (@(posedge clk) disable iff (!n_rst)
        (state_q == cache_pkg::IDLE) |-> !i_biu_done)
        else $error("cache_ctrl: done pulse in IDLE");

    // Relies on the requester holding its address through a miss
    assert property (@(posedge clk) disable iff (!n_rst)
        (o_biu_en && !i_biu_done) |=> $stable(o_biu_addr))
        else $error("cache_ctrl: line address changed during a transfer");

endmodule

//--- source/cache_pkg.sv
package cache_pkg;

    // Geometry defaults, overridden through the top level parameters
    localparam int DATA_WIDTH      = 32;   // Word width in bits
    localparam int ADDR_WIDTH      = 12;   // Byte address width
    localparam int CACHE_SIZE      = 256;  // Data capacity in bytes
    localparam int CACHE_LINE_SIZE = 16;   // Four words per line, sixteen lines

    // Controller states
    // IDLE serves hits, MISS fetches the requested line and VICTIM writes the
    // captured dirty line back to memory
    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        MISS   = 2'b01,
        VICTIM = 2'b10
    } ctrl_state_t;

endpackage

//--- source/cache_store.sv
`timescale 1ns/1ps

module cache_store #(
    parameter int  DATA_WIDTH      = cache_pkg::DATA_WIDTH,
    parameter int  ADDR_WIDTH      = cache_pkg::ADDR_WIDTH,
    parameter int  CACHE_SIZE      = cache_pkg::CACHE_SIZE,
    parameter int  CACHE_LINE_SIZE = cache_pkg::CACHE_LINE_SIZE,
    localparam int LINE_COUNT      = CACHE_SIZE / CACHE_LINE_SIZE,
    localparam int OFFSET_WIDTH    = $clog2(CACHE_LINE_SIZE),
    localparam int INDEX_WIDTH     = $clog2(LINE_COUNT),
    localparam int TAG_WIDTH       = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH,
    localparam int LINE_WIDTH      = CACHE_LINE_SIZE * 8
) (
    input  logic                    clk,
    input  logic                    n_rst,

    input  logic                    i_re,
    input  logic                    i_we,
    input  logic                    i_fe,
    input  logic [OFFSET_WIDTH-1:0] i_offset,
    input  logic [INDEX_WIDTH-1:0]  i_index,
    input  logic [TAG_WIDTH-1:0]    i_tag,
    input  logic [LINE_WIDTH-1:0]   i_fdata,
    input  logic [DATA_WIDTH-1:0]   i_wdata,

    output logic                    o_hit,
    output logic                    o_dirty,
    output logic [TAG_WIDTH-1:0]    o_tag,
    output logic [LINE_WIDTH-1:0]   o_vdata,
    output logic [DATA_WIDTH-1:0]   o_rdata
);

    localparam int BYTE_SEL_WIDTH = $clog2(DATA_WIDTH / 8);
    localparam int WORD_SEL_WIDTH = OFFSET_WIDTH - BYTE_SEL_WIDTH;

    logic [LINE_WIDTH-1:0]     data_q [LINE_COUNT];
    logic [TAG_WIDTH-1:0]      tag_q  [LINE_COUNT];
    logic [LINE_COUNT-1:0]     valid_q;
    logic [LINE_COUNT-1:0]     dirty_q;

    logic [WORD_SEL_WIDTH-1:0] word_sel;
    logic                      tag_match;
    logic                      wr_hit;

    assign word_sel  = i_offset[OFFSET_WIDTH-1:BYTE_SEL_WIDTH];  // Byte bits are ignored
    assign tag_match = valid_q[i_index] && (tag_q[i_index] == i_tag);
    assign wr_hit    = i_we && tag_match;

    assign o_hit     = tag_match && (i_re || i_we);
    assign o_dirty   = valid_q[i_index] && dirty_q[i_index];  // An invalid line is never a victim
    assign o_tag     = tag_q[i_index];
    assign o_vdata   = data_q[i_index];
    assign o_rdata   = data_q[i_index][word_sel*DATA_WIDTH +: DATA_WIDTH];

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (i_fe) begin
            valid_q[i_index] <= 1'b1;
            dirty_q[i_index] <= 1'b0;  // Freshly fetched line matches memory
        end else if (wr_hit) begin
            dirty_q[i_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (i_fe) begin
            data_q[i_index] <= i_fdata;
            tag_q[i_index]  <= i_tag;
        end else if (wr_hit) begin
            data_q[i_index][word_sel*DATA_WIDTH +: DATA_WIDTH] <= i_wdata;
        end
    end

    // The controller only fills from MISS and only writes from IDLE
    assert property (@(posedge clk) disable iff (!n_rst) !(i_fe && i_we))
        else $error("cache_store: fill and write in the same cycle");

endmodule

//--- source/cache_subsystem.sv
`timescale 1ns/1ps

module cache_subsystem #(
    parameter int  DATA_WIDTH      = cache_pkg::DATA_WIDTH,
    parameter int  ADDR_WIDTH      = cache_pkg::ADDR_WIDTH,
    parameter int  CACHE_SIZE      = cache_pkg::CACHE_SIZE,
    parameter int  CACHE_LINE_SIZE = cache_pkg::CACHE_LINE_SIZE,
    localparam int LINE_WIDTH      = CACHE_LINE_SIZE * 8,
    localparam int STRB_WIDTH      = DATA_WIDTH / 8
) (
    input  logic                  clk,
    input  logic                  n_rst,

    input  logic                  i_re,
    input  logic                  i_we,
    input  logic [ADDR_WIDTH-1:0] i_addr,
    input  logic [DATA_WIDTH-1:0] i_wdata,
    output logic [DATA_WIDTH-1:0] o_rdata,
    output logic                  o_hit,
    output logic                  o_busy,

    output logic [ADDR_WIDTH-1:0] o_araddr,
    output logic                  o_arvalid,
    input  logic                  i_arready,
    input  logic [DATA_WIDTH-1:0] i_rdata,
    input  logic [1:0]            i_rresp,
    input  logic                  i_rvalid,
    output logic                  o_rready,
    output logic [ADDR_WIDTH-1:0] o_awaddr,
    output logic                  o_awvalid,
    input  logic                  i_awready,
    output logic [DATA_WIDTH-1:0] o_wdata,
    output logic [STRB_WIDTH-1:0] o_wstrb,
    output logic                  o_wvalid,
    input  logic                  i_wready,
    input  logic [1:0]            i_bresp,
    input  logic                  i_bvalid,
    output logic                  o_bready
);

    logic                  biu_en;
    logic                  biu_we;
    logic                  biu_done;
    logic [ADDR_WIDTH-1:0] biu_addr;
    logic [LINE_WIDTH-1:0] biu_wr_line;  // Victim line towards memory
    logic [LINE_WIDTH-1:0] biu_rd_line;  // Fetched line towards the store

    cache_ctrl #(
        .DATA_WIDTH(DATA_WIDTH),
        .ADDR_WIDTH(ADDR_WIDTH),
        .CACHE_SIZE(CACHE_SIZE),
        .CACHE_LINE_SIZE(CACHE_LINE_SIZE)
    ) ctrl_inst (
        .clk(clk),
        .n_rst(n_rst),
        .i_re(i_re),
        .i_we(i_we),
        .i_addr(i_addr),
        .i_wdata(i_wdata),
        .o_rdata(o_rdata),
        .o_hit(o_hit),
        .o_busy(o_busy),
        .i_biu_done(biu_done),
        .i_biu_data(biu_rd_line),
        .o_biu_en(biu_en),
        .o_biu_we(biu_we),
        .o_biu_addr(biu_addr),
        .o_biu_data(biu_wr_line)
    );

    line_biu #(
        .DATA_WIDTH(DATA_WIDTH),
        .ADDR_WIDTH(ADDR_WIDTH),
        .CACHE_LINE_SIZE(CACHE_LINE_SIZE)
    ) biu_inst (
        .clk(clk),
        .n_rst(n_rst),
        .i_en(biu_en),
        .i_we(biu_we),
        .i_addr(biu_addr),
        .i_data(biu_wr_line),
        .o_done(biu_done),
        .o_data(biu_rd_line),
        .o_araddr(o_araddr),
        .o_arvalid(o_arvalid),
        .i_arready(i_arready),
        .i_rdata(i_rdata),
        .i_rresp(i_rresp),
        .i_rvalid(i_rvalid),
        .o_rready(o_rready),
        .o_awaddr(o_awaddr),
        .o_awvalid(o_awvalid),
        .i_awready(i_awready),
        .o_wdata(o_wdata),
        .o_wstrb(o_wstrb),
        .o_wvalid(o_wvalid),
        .i_wready(i_wready),
        .i_bresp(i_bresp),
        .i_bvalid(i_bvalid),
        .o_bready(o_bready)
    );

endmodule

//--- source/line_biu.sv
`timescale 1ns/1ps

module line_biu #(
    parameter int  DATA_WIDTH      = cache_pkg::DATA_WIDTH,
    parameter int  ADDR_WIDTH      = cache_pkg::ADDR_WIDTH,
    parameter int  CACHE_LINE_SIZE = cache_pkg::CACHE_LINE_SIZE,
    localparam int LINE_WIDTH      = CACHE_LINE_SIZE * 8,
    localparam int OFFSET_WIDTH    = $clog2(CACHE_LINE_SIZE),
    localparam int STRB_WIDTH      = DATA_WIDTH / 8
) (
    input  logic                  clk,
    input  logic                  n_rst,

    input  logic                  i_en,
    input  logic                  i_we,
    input  logic [ADDR_WIDTH-1:0] i_addr,
    input  logic [LINE_WIDTH-1:0] i_data,
    output logic                  o_done,
    output logic [LINE_WIDTH-1:0] o_data,

    output logic [ADDR_WIDTH-1:0] o_araddr,
    output logic                  o_arvalid,
    input  logic                  i_arready,
    input  logic [DATA_WIDTH-1:0] i_rdata,
    input  logic [1:0]            i_rresp,
    input  logic                  i_rvalid,
    output logic                  o_rready,

    output logic [ADDR_WIDTH-1:0] o_awaddr,
    output logic                  o_awvalid,
    input  logic                  i_awready,
    output logic [DATA_WIDTH-1:0] o_wdata,
    output logic [STRB_WIDTH-1:0] o_wstrb,
    output logic                  o_wvalid,
    input  logic                  i_wready,
    input  logic [1:0]            i_bresp,
    input  logic                  i_bvalid,
    output logic                  o_bready
);

    localparam int WORD_COUNT     = LINE_WIDTH / DATA_WIDTH;
    localparam int CNT_WIDTH      = $clog2(WORD_COUNT);
    localparam int BYTE_SEL_WIDTH = $clog2(STRB_WIDTH);

    axi_pkg::biu_state_t   state_q;
    axi_pkg::biu_state_t   state_d;

    logic [CNT_WIDTH-1:0]  cnt_q;
    logic                  last_word;
    logic                  word_end;
    logic                  aw_fire;
    logic                  w_fire;
    logic                  aw_sent_q;
    logic                  w_sent_q;
    logic                  done_q;
    logic [LINE_WIDTH-1:0] line_q;
    logic [ADDR_WIDTH-1:0] word_addr;

    assign last_word = cnt_q == CNT_WIDTH'(WORD_COUNT - 1);
    assign word_addr = {i_addr[ADDR_WIDTH-1:OFFSET_WIDTH], cnt_q, {BYTE_SEL_WIDTH{1'b0}}};
    assign word_end  = ((state_q == axi_pkg::B_RDATA) && i_rvalid) ||
                       ((state_q == axi_pkg::B_WRESP) && i_bvalid);

    assign aw_fire   = o_awvalid && i_awready;
    assign w_fire    = o_wvalid && i_wready;

    assign o_araddr  = word_addr;
    assign o_arvalid = state_q == axi_pkg::B_RADDR;
    assign o_rready  = state_q == axi_pkg::B_RDATA;
    assign o_awaddr  = word_addr;
    assign o_awvalid = (state_q == axi_pkg::B_WADDR) && !aw_sent_q;  // Each drops on its own
    assign o_wvalid  = (state_q == axi_pkg::B_WADDR) && !w_sent_q;
    assign o_wdata   = i_data[cnt_q*DATA_WIDTH +: DATA_WIDTH];
    assign o_wstrb   = '1;
    assign o_bready  = state_q == axi_pkg::B_WRESP;
    assign o_done    = done_q;
    assign o_data    = line_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            axi_pkg::B_IDLE: begin
                // Enable is still high in the done cycle, so that cycle is skipped
                if (i_en && !done_q) begin
                    state_d = i_we ? axi_pkg::B_WADDR : axi_pkg::B_RADDR;
                end
            end
            axi_pkg::B_RADDR: begin
                if (i_arready) begin
                    state_d = axi_pkg::B_RDATA;
                end
            end
            axi_pkg::B_RDATA: begin
                if (i_rvalid) begin
                    state_d = last_word ? axi_pkg::B_IDLE : axi_pkg::B_RADDR;
                end
            end
            axi_pkg::B_WADDR: begin
                if ((aw_sent_q || aw_fire) && (w_sent_q || w_fire)) begin
                    state_d = axi_pkg::B_WRESP;
                end
            end
            axi_pkg::B_WRESP: begin
                if (i_bvalid) begin
                    state_d = last_word ? axi_pkg::B_IDLE : axi_pkg::B_WADDR;
                end
            end
            default: state_d = axi_pkg::B_IDLE;
        endcase
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state_q   <= axi_pkg::B_IDLE;
            cnt_q     <= '0;
            aw_sent_q <= 1'b0;
            w_sent_q  <= 1'b0;
            done_q    <= 1'b0;
        end else begin
            state_q <= state_d;
            done_q  <= word_end && last_word;
            if (state_q == axi_pkg::B_IDLE) begin
                cnt_q <= '0;
            end else if (word_end) begin
                cnt_q <= cnt_q + 1'b1;
            end
            if (state_q != axi_pkg::B_WADDR) begin
                aw_sent_q <= 1'b0;
                w_sent_q  <= 1'b0;
            end else begin
                aw_sent_q <= aw_sent_q || aw_fire;
                w_sent_q  <= w_sent_q || w_fire;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (o_rready && i_rvalid) begin
            line_q[cnt_q*DATA_WIDTH +: DATA_WIDTH] <= i_rdata;
        end
    end

    assert property (@(posedge clk) disable iff (!n_rst)
        (o_arvalid && !i_arready) |=> (o_arvalid && $stable(o_araddr)))
        else $error("line_biu: arvalid dropped before arready");

    // Error responses are not recovered, the data is taken as is
    assert property (@(posedge clk) disable iff (!n_rst)
        (i_rvalid && o_rready) |-> (axi_pkg::axi_resp_t'(i_rresp) == axi_pkg::OKAY))
        else $error("line_biu: read response %0d at %h", i_rresp, o_araddr);

    assert property (@(posedge clk) disable iff (!n_rst)
        (i_bvalid && o_bready) |-> (axi_pkg::axi_resp_t'(i_bresp) == axi_pkg::OKAY))
        else $error("line_biu: write response %0d at %h", i_bresp, o_awaddr);

endmodule

//--- test/axi_mem_model.sv
`timescale 1ns/1ps

module axi_mem_model #(
    parameter int                    DATA_WIDTH   = 32,
    parameter int                    ADDR_WIDTH   = 12,
    parameter logic [DATA_WIDTH-1:0] FILL_PATTERN = '0,
    localparam int                   MEM_WORDS    = 2 ** (ADDR_WIDTH - 2),
    localparam int                   STRB_WIDTH   = DATA_WIDTH / 8
) (
    input  logic                  clk,
    input  logic                  n_rst,

    input  logic [ADDR_WIDTH-1:0] i_araddr,
    input  logic                  i_arvalid,
    output logic                  o_arready,
    output logic [DATA_WIDTH-1:0] o_rdata,
    output logic [1:0]            o_rresp,
    output logic                  o_rvalid,
    input  logic                  i_rready,

    input  logic [ADDR_WIDTH-1:0] i_awaddr,
    input  logic                  i_awvalid,
    output logic                  o_awready,
    input  logic [DATA_WIDTH-1:0] i_wdata,
    input  logic [STRB_WIDTH-1:0] i_wstrb,
    input  logic                  i_wvalid,
    output logic                  o_wready,
    output logic [1:0]            o_bresp,
    output logic                  o_bvalid,
    input  logic                  i_bready
);

    logic [DATA_WIDTH-1:0] mem [MEM_WORDS];

    logic                  rst_s;
    logic                  ar_seen;
    logic                  aw_seen;
    logic                  w_seen;
    logic                  ar_hs;
    logic                  r_hs;
    logic                  aw_hs;
    logic                  w_hs;
    logic                  b_hs;
    logic [ADDR_WIDTH-1:0] ar_addr_s;
    logic [ADDR_WIDTH-1:0] aw_addr_s;
    logic [ADDR_WIDTH-1:0] aw_addr_q;
    logic [DATA_WIDTH-1:0] w_data_s;
    logic [DATA_WIDTH-1:0] w_data_q;
    logic [STRB_WIDTH-1:0] w_strb_s;
    logic [STRB_WIDTH-1:0] w_strb_q;
    logic                  aw_got;
    logic                  w_got;
    logic                  r_pend;
    logic                  b_pend;
    int                    ar_wait;
    int                    r_wait;
    int                    aw_wait;
    int                    w_wait;
    int                    b_wait;

    task automatic idle_bus();
        o_arready = 1'b0;
        o_rvalid  = 1'b0;
        o_rdata   = '0;
        o_rresp   = axi_pkg::OKAY;
        o_awready = 1'b0;
        o_wready  = 1'b0;
        o_bvalid  = 1'b0;
        o_bresp   = axi_pkg::OKAY;
        aw_got    = 1'b0;
        w_got     = 1'b0;
        r_pend    = 1'b0;
        b_pend    = 1'b0;
        ar_wait   = $urandom % 4;
        aw_wait   = $urandom % 4;
        w_wait    = $urandom % 4;
    endtask

    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = DATA_WIDTH'(i) ^ FILL_PATTERN;  // Every word differs from its neighbours
        end
        idle_bus();
        forever begin
            // Handshakes are taken from the values present at the rising edge
            @(posedge clk);
            rst_s     = !n_rst;
            ar_seen   = i_arvalid;
            aw_seen   = i_awvalid;
            w_seen    = i_wvalid;
            ar_hs     = i_arvalid && o_arready;
            r_hs      = o_rvalid && i_rready;
            aw_hs     = i_awvalid && o_awready;
            w_hs      = i_wvalid && o_wready;
            b_hs      = o_bvalid && i_bready;
            ar_addr_s = i_araddr;
            aw_addr_s = i_awaddr;
            w_data_s  = i_wdata;
            w_strb_s  = i_wstrb;
            #2;
            if (rst_s) begin
                idle_bus();
            end else begin
                if (r_hs) o_rvalid = 1'b0;
                if (r_pend) begin
                    if (r_wait == 0) begin
                        o_rvalid = 1'b1;
                        r_pend   = 1'b0;
                    end else begin
                        r_wait--;
                    end
                end
                if (ar_hs) begin
                    o_arready = 1'b0;
                    o_rdata   = mem[int'(ar_addr_s[ADDR_WIDTH-1:2])];
                    r_pend    = 1'b1;
                    r_wait    = $urandom % 4;
                end else if (ar_seen && !o_arready) begin
                    if (ar_wait == 0) begin
                        o_arready = 1'b1;
                        ar_wait   = $urandom % 4;
                    end else begin
                        ar_wait--;
                    end
                end

                if (b_hs) o_bvalid = 1'b0;
                if (b_pend) begin
                    if (b_wait == 0) begin
                        o_bvalid = 1'b1;
                        b_pend   = 1'b0;
                    end else begin
                        b_wait--;
                    end
                end
                // Address and data are accepted on their own delays
                if (aw_hs) begin
                    o_awready = 1'b0;
                    aw_got    = 1'b1;
                    aw_addr_q = aw_addr_s;
                end else if (aw_seen && !o_awready) begin
                    if (aw_wait == 0) begin
                        o_awready = 1'b1;
                        aw_wait   = $urandom % 4;
                    end else begin
                        aw_wait--;
                    end
                end
                if (w_hs) begin
                    o_wready = 1'b0;
                    w_got    = 1'b1;
                    w_data_q = w_data_s;
                    w_strb_q = w_strb_s;
                end else if (w_seen && !o_wready) begin
                    if (w_wait == 0) begin
                        o_wready = 1'b1;
                        w_wait   = $urandom % 4;
                    end else begin
                        w_wait--;
                    end
                end
                if (aw_got && w_got) begin
                    // Only the bytes enabled by the strobe are written
                    for (int b = 0; b < STRB_WIDTH; b++) begin
                        if (w_strb_q[b]) begin
                            mem[int'(aw_addr_q[ADDR_WIDTH-1:2])][b*8 +: 8] = w_data_q[b*8 +: 8];
                        end
                    end
                    aw_got = 1'b0;
                    w_got  = 1'b0;
                    b_pend = 1'b1;
                    b_wait = $urandom % 4;
                end
            end
        end
    end

endmodule

//--- test/tb_cache_subsystem.sv
`timescale 1ns/1ps

module tb_cache_subsystem;

    localparam int          DATA_WIDTH      = cache_pkg::DATA_WIDTH;
    localparam int          ADDR_WIDTH      = cache_pkg::ADDR_WIDTH;
    localparam int          CACHE_SIZE      = cache_pkg::CACHE_SIZE;
    localparam int          CACHE_LINE_SIZE = cache_pkg::CACHE_LINE_SIZE;
    localparam int          MEM_WORDS       = 2 ** (ADDR_WIDTH - 2);
    localparam logic [31:0] FILL_PATTERN    = 32'h6b2e_94c1;
    localparam int          RANDOM_COUNT    = 400;
    localparam int          CYCLE_LIMIT     = RANDOM_COUNT * 2 * 8 * 5 + 6000;
    localparam logic [11:0] DIRTY_ADDR      = 12'h048;
    localparam logic [11:0] CONFLICT_ADDR   = 12'h148;  // Same index as DIRTY_ADDR, next tag

    logic                  clk;
    logic                  n_rst;
    logic                  i_re;
    logic                  i_we;
    logic [ADDR_WIDTH-1:0] i_addr;
    logic [DATA_WIDTH-1:0] i_wdata;
    logic [DATA_WIDTH-1:0] o_rdata;
    logic                  o_hit;
    logic                  o_busy;

    logic [ADDR_WIDTH-1:0] araddr;
    logic                  arvalid;
    logic                  arready;
    logic [DATA_WIDTH-1:0] rdata;
    logic [1:0]            rresp;
    logic                  rvalid;
    logic                  rready;
    logic [ADDR_WIDTH-1:0] awaddr;
    logic                  awvalid;
    logic                  awready;
    logic [DATA_WIDTH-1:0] wdata;
    logic [3:0]            wstrb;
    logic                  wvalid;
    logic                  wready;
    logic [1:0]            bresp;
    logic                  bvalid;
    logic                  bready;

    logic [DATA_WIDTH-1:0] model_mem [MEM_WORDS];
    logic                  written   [MEM_WORDS];
    int                    cycle_count = 0;

    cache_subsystem #(
        .DATA_WIDTH(DATA_WIDTH),
        .ADDR_WIDTH(ADDR_WIDTH),
        .CACHE_SIZE(CACHE_SIZE),
        .CACHE_LINE_SIZE(CACHE_LINE_SIZE)
    ) UUT (
        .clk(clk), .n_rst(n_rst),
        .i_re(i_re), .i_we(i_we), .i_addr(i_addr), .i_wdata(i_wdata),
        .o_rdata(o_rdata), .o_hit(o_hit), .o_busy(o_busy),
        .o_araddr(araddr), .o_arvalid(arvalid), .i_arready(arready),
        .i_rdata(rdata), .i_rresp(rresp), .i_rvalid(rvalid), .o_rready(rready),
        .o_awaddr(awaddr), .o_awvalid(awvalid), .i_awready(awready),
        .o_wdata(wdata), .o_wstrb(wstrb), .o_wvalid(wvalid), .i_wready(wready),
        .i_bresp(bresp), .i_bvalid(bvalid), .o_bready(bready)
    );

    axi_mem_model #(
        .DATA_WIDTH(DATA_WIDTH),
        .ADDR_WIDTH(ADDR_WIDTH),
        .FILL_PATTERN(FILL_PATTERN)
    ) slave (
        .clk(clk), .n_rst(n_rst),
        .i_araddr(araddr), .i_arvalid(arvalid), .o_arready(arready),
        .o_rdata(rdata), .o_rresp(rresp), .o_rvalid(rvalid), .i_rready(rready),
        .i_awaddr(awaddr), .i_awvalid(awvalid), .o_awready(awready),
        .i_wdata(wdata), .i_wstrb(wstrb), .i_wvalid(wvalid), .o_wready(wready),
        .o_bresp(bresp), .o_bvalid(bvalid), .i_bready(bready)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("timeout: no result after %0d cycles", cycle_count);
            $display("STATUS: FAIL");
            $fatal(1);
        end
    end

    function automatic int word_index(input logic [ADDR_WIDTH-1:0] addr);
        return int'(addr[ADDR_WIDTH-1:2]);
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("error %s expected %h actual %h", name, expected, actual);
            $display("STATUS: FAIL");
            $fatal(1);
        end
    endtask

    // Holds the request until a hit, entered and left 2 ns after a rising edge
    task automatic access(input logic we, input logic [ADDR_WIDTH-1:0] addr,
                          input logic [DATA_WIDTH-1:0] value, input string name,
                          output int wait_cycles, output logic saw_busy);
        int word;
        word        = word_index(addr);
        wait_cycles = 0;
        saw_busy    = 1'b0;
        i_re        = !we;
        i_we        = we;
        i_addr      = addr;
        i_wdata     = value;
        @(negedge clk);
        while (!o_hit) begin
            saw_busy = saw_busy || o_busy;
            wait_cycles++;
            @(negedge clk);
        end
        check({name, " busy at hit"}, '0, 32'(o_busy));
        if (we) begin
            model_mem[word] = value;
            written[word]   = 1'b1;
        end else begin
            check(name, model_mem[word], o_rdata);
        end
        @(posedge clk);
        #2;
        i_re = 1'b0;
        i_we = 1'b0;
    endtask

    initial begin
        int                    wait_cycles;
        logic                  saw_busy;
        logic                  we;
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] value;

        void'($urandom(32'h797f2d8c));
        clk     = 1'b0;
        n_rst   = 1'b0;
        i_re    = 1'b0;
        i_we    = 1'b0;
        i_addr  = '0;
        i_wdata = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            model_mem[i] = DATA_WIDTH'(i) ^ FILL_PATTERN;
            written[i]   = 1'b0;
        end
        repeat (16) @(posedge clk);
        #2;
        n_rst = 1'b1;

        repeat (6) begin
            @(negedge clk);
            check("reset busy", '0, 32'(o_busy));
            check("reset hit", '0, 32'(o_hit));
            check("reset arvalid", '0, 32'(arvalid));
            check("reset awvalid", '0, 32'(awvalid));
            check("reset wvalid", '0, 32'(wvalid));
        end
        @(posedge clk);
        #2;

        access(1'b0, 12'h120, '0, "cold miss", wait_cycles, saw_busy);
        check("cold miss busy", 1, 32'(saw_busy));
        access(1'b0, 12'h12c, '0, "same line", wait_cycles, saw_busy);
        check("same line wait", 0, 32'(wait_cycles));
        check("same line busy", 0, 32'(saw_busy));
        access(1'b1, 12'h124, 32'h1234_5678, "write hit", wait_cycles, saw_busy);
        access(1'b0, 12'h124, '0, "read after write", wait_cycles, saw_busy);

        // A dirty line pushed out by a conflicting tag must reach memory
        access(1'b1, DIRTY_ADDR, 32'h0bad_cafe, "dirty write", wait_cycles, saw_busy);
        access(1'b0, CONFLICT_ADDR, '0, "conflict read", wait_cycles, saw_busy);
        check("conflict busy", 1, 32'(saw_busy));
        check("write-back image", 32'h0bad_cafe, slave.mem[word_index(DIRTY_ADDR)]);
        access(1'b0, DIRTY_ADDR, '0, "refetch", wait_cycles, saw_busy);

        for (int n = 0; n < RANDOM_COUNT; n++) begin
            we    = 1'($urandom % 2);
            addr  = ADDR_WIDTH'(($urandom % 256) * 4);  // 1 KB window, four tags per index
            value = $urandom;
            access(we, addr, value, $sformatf("random %0d", n), wait_cycles, saw_busy);
        end

        // Reading a clean region outside the window evicts every dirty line
        for (int i = 0; i < CACHE_SIZE / CACHE_LINE_SIZE; i++) begin
            addr = ADDR_WIDTH'(12'hc00 + i * CACHE_LINE_SIZE);
            access(1'b0, addr, '0, "flush", wait_cycles, saw_busy);
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            if (written[i]) begin
                check($sformatf("memory image %h", i * 4), model_mem[i], slave.mem[i]);
            end
        end

        $display("STATUS: PASS");
        $finish;
    end

endmodule
